// File: Makefile
# Verilator build and run of the scratchpad testbench

TB_TOP = tb_mem_island

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 --top-module $(TB_TOP) -f mem_island_top.f -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --top-module mem_island_top \
	  design/mem_island_pkg.sv design/bank_port_if.sv design/narrow_router.sv \
	  design/wide_splitter.sv design/bank_arbiter.sv design/sram_bank.sv \
	  design/mem_island_top.sv

clean:
	rm -rf obj_dir

// File: design/bank_arbiter.sv
// Narrow/wide arbitration per wide bank; narrow wins unless the wide port has lost
// WidePriorityWait contention cycles in a row. A wide access needs both lanes at once.
`timescale 1ns/1ps

module bank_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  mem_island_pkg::bank_mask_t   narrow_bank_req_i,
  input  mem_island_pkg::bank_addr_t   narrow_bank_addr_i,
  input  logic                         narrow_we_i,
  input  mem_island_pkg::narrow_data_t narrow_wdata_i,
  input  mem_island_pkg::narrow_strb_t narrow_strb_i,
  input  mem_island_pkg::bank_mask_t   wide_bank_req_i,
  input  mem_island_pkg::bank_addr_t   wide_bank_addr_i,
  input  logic                         wide_we_i,
  input  mem_island_pkg::narrow_data_t wide_wdata_i [mem_island_pkg::NumLanes],
  input  mem_island_pkg::narrow_strb_t wide_strb_i  [mem_island_pkg::NumLanes],
  output logic                         narrow_gnt_o,
  output logic                         wide_gnt_o,
  bank_port_if.arbiter                 bank_o [mem_island_pkg::NumBanks]
);

  localparam int unsigned NumWide  = mem_island_pkg::NumWideBanks;
  localparam int unsigned NumLanes = mem_island_pkg::NumLanes;
  localparam int unsigned WaitMax  = mem_island_pkg::WidePriorityWait;

  logic [NumWide-1:0] narrow_hit;
  logic [NumWide-1:0] wide_hit;
  logic [NumWide-1:0] contention;
  logic [NumWide-1:0] wide_win;

  for (genvar w = 0; w < NumWide; w++) begin : gen_wide_bank
    mem_island_pkg::prio_cnt_t wait_q;

    assign narrow_hit[w] = |narrow_bank_req_i[w*NumLanes +: NumLanes];
    assign wide_hit[w]   = &wide_bank_req_i[w*NumLanes +: NumLanes];
    assign contention[w] = narrow_hit[w] & wide_hit[w];
    assign wide_win[w]   = contention[w] && (WaitMax != 0) &&
                           (wait_q == mem_island_pkg::prio_cnt_t'(WaitMax));

    // Count lost wide cycles, cleared on a win or when the contention ends
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wait_q <= '0;
      end else if (contention[w] && !wide_win[w] && (WaitMax != 0)) begin
        wait_q <= wait_q + 1'b1;
      end else begin
        wait_q <= '0;
      end
    end
  end

  assign narrow_gnt_o = (|narrow_bank_req_i) & ~(|wide_win);
  assign wide_gnt_o   = |(wide_hit & (wide_win | ~narrow_hit));

  // Grants are exclusive per bank, so the wide select alone steers the fields
  for (genvar b = 0; b < mem_island_pkg::NumBanks; b++) begin : gen_bank
    logic narrow_sel;
    logic wide_sel;

    assign narrow_sel      = narrow_bank_req_i[b] & narrow_gnt_o;
    assign wide_sel        = wide_bank_req_i[b] & wide_gnt_o;
    assign bank_o[b].req   = narrow_sel | wide_sel;
    assign bank_o[b].we    = wide_sel ? wide_we_i : narrow_we_i;
    assign bank_o[b].addr  = wide_sel ? wide_bank_addr_i : narrow_bank_addr_i;
    assign bank_o[b].wdata = wide_sel ? wide_wdata_i[b % NumLanes] : narrow_wdata_i;
    assign bank_o[b].strb  = wide_sel ? wide_strb_i[b % NumLanes] : narrow_strb_i;
  end

endmodule

// File: design/bank_port_if.sv
// Request and read data of one 32-bit SRAM bank.
// Read data is valid one cycle after a read request.
`timescale 1ns/1ps

interface bank_port_if;

  logic                         req;
  logic                         we;
  mem_island_pkg::bank_addr_t   addr;
  mem_island_pkg::narrow_data_t wdata;
  mem_island_pkg::narrow_strb_t strb;
  mem_island_pkg::narrow_data_t rdata;

  // Request side, driven by the arbiter
  modport arbiter (output req, we, addr, wdata, strb, input rdata);

  // Memory side
  modport bank (input req, we, addr, wdata, strb, output rdata);

endinterface

// File: design/mem_island_pkg.sv
// Address layout, widths and shared types of the banked scratchpad.
// Banks are interleaved on address bits 3:2; the layout assumes four 32-bit banks.
package mem_island_pkg;

  localparam int unsigned AddrWidth    = 12;
  localparam int unsigned NarrowWidth  = 32;
  localparam int unsigned WideWidth    = 64;
  localparam int unsigned NumLanes     = 2;
  localparam int unsigned NumWideBanks = 2;
  localparam int unsigned NumBanks     = 4;
  localparam int unsigned WordsPerBank = 256;

  // Byte address fields
  localparam int unsigned LaneBit     = 2;
  localparam int unsigned WideBankBit = 3;
  localparam int unsigned WordLsb     = 4;

  // Lost contention cycles before the wide port wins once, 0 keeps narrow on top
  localparam int unsigned WidePriorityWait = 1;

  localparam int unsigned PrioCntWidth =
    (WidePriorityWait > 0) ? $clog2(WidePriorityWait + 1) : 1;

  typedef logic [AddrWidth-1:0]              addr_t;
  typedef logic [NarrowWidth-1:0]            narrow_data_t;
  typedef logic [NarrowWidth/8-1:0]          narrow_strb_t;
  typedef logic [WideWidth-1:0]              wide_data_t;
  typedef logic [WideWidth/8-1:0]            wide_strb_t;
  typedef logic [$clog2(WordsPerBank)-1:0]   bank_addr_t;
  typedef logic [$clog2(NumBanks)-1:0]       bank_sel_t;
  typedef logic [NumBanks-1:0]               bank_mask_t;
  typedef logic [PrioCntWidth-1:0]           prio_cnt_t;

endpackage

// File: design/mem_island_top.sv
// Banked scratchpad with one 32-bit and one 64-bit port over four 32-bit banks.
// Both ports answer one cycle after the grant; there is no response back-pressure.
`timescale 1ns/1ps

module mem_island_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Narrow port
  input  logic                         narrow_req_i,
  output logic                         narrow_gnt_o,
  input  mem_island_pkg::addr_t        narrow_addr_i,
  input  logic                         narrow_we_i,
  input  mem_island_pkg::narrow_data_t narrow_wdata_i,
  input  mem_island_pkg::narrow_strb_t narrow_strb_i,
  output logic                         narrow_rvalid_o,
  output mem_island_pkg::narrow_data_t narrow_rdata_o,
  // Wide port
  input  logic                         wide_req_i,
  output logic                         wide_gnt_o,
  input  mem_island_pkg::addr_t        wide_addr_i,
  input  logic                         wide_we_i,
  input  mem_island_pkg::wide_data_t   wide_wdata_i,
  input  mem_island_pkg::wide_strb_t   wide_strb_i,
  output logic                         wide_rvalid_o,
  output mem_island_pkg::wide_data_t   wide_rdata_o
);

  mem_island_pkg::bank_mask_t   narrow_bank_req;
  mem_island_pkg::bank_addr_t   narrow_bank_addr;
  logic                         narrow_we;
  mem_island_pkg::narrow_data_t narrow_wdata;
  mem_island_pkg::narrow_strb_t narrow_strb;
  logic                         narrow_gnt;

  mem_island_pkg::bank_mask_t   wide_bank_req;
  mem_island_pkg::bank_addr_t   wide_bank_addr;
  logic                         wide_we;
  mem_island_pkg::narrow_data_t wide_lane_wdata [mem_island_pkg::NumLanes];
  mem_island_pkg::narrow_strb_t wide_lane_strb  [mem_island_pkg::NumLanes];
  logic                         wide_gnt;

  mem_island_pkg::narrow_data_t bank_rdata [mem_island_pkg::NumBanks];

  bank_port_if bank_if [mem_island_pkg::NumBanks] ();

  narrow_router i_narrow_router (
    .clk_i, .rst_ni,
    .req_i(narrow_req_i), .addr_i(narrow_addr_i), .we_i(narrow_we_i),
    .wdata_i(narrow_wdata_i), .strb_i(narrow_strb_i), .gnt_i(narrow_gnt),
    .bank_rdata_i(bank_rdata), .bank_req_o(narrow_bank_req), .bank_addr_o(narrow_bank_addr),
    .we_o(narrow_we), .wdata_o(narrow_wdata), .strb_o(narrow_strb),
    .gnt_o(narrow_gnt_o), .rvalid_o(narrow_rvalid_o), .rdata_o(narrow_rdata_o)
  );

  wide_splitter i_wide_splitter (
    .clk_i, .rst_ni,
    .req_i(wide_req_i), .addr_i(wide_addr_i), .we_i(wide_we_i),
    .wdata_i(wide_wdata_i), .strb_i(wide_strb_i), .gnt_i(wide_gnt),
    .bank_rdata_i(bank_rdata), .bank_req_o(wide_bank_req), .bank_addr_o(wide_bank_addr),
    .we_o(wide_we), .lane_wdata_o(wide_lane_wdata), .lane_strb_o(wide_lane_strb),
    .gnt_o(wide_gnt_o), .rvalid_o(wide_rvalid_o), .rdata_o(wide_rdata_o)
  );

  bank_arbiter i_bank_arbiter (
    .clk_i, .rst_ni,
    .narrow_bank_req_i(narrow_bank_req), .narrow_bank_addr_i(narrow_bank_addr),
    .narrow_we_i(narrow_we), .narrow_wdata_i(narrow_wdata), .narrow_strb_i(narrow_strb),
    .wide_bank_req_i(wide_bank_req), .wide_bank_addr_i(wide_bank_addr),
    .wide_we_i(wide_we), .wide_wdata_i(wide_lane_wdata), .wide_strb_i(wide_lane_strb),
    .narrow_gnt_o(narrow_gnt), .wide_gnt_o(wide_gnt), .bank_o(bank_if)
  );

  for (genvar b = 0; b < mem_island_pkg::NumBanks; b++) begin : gen_bank
    sram_bank i_sram_bank (
      .clk_i,
      .rst_ni,
      .port_i(bank_if[b])
    );
    assign bank_rdata[b] = bank_if[b].rdata;
  end

endmodule

// File: design/narrow_router.sv
// Routes the 32-bit port to one bank picked by address bits 3:2.
// Expects gnt_i only while a request is present.
`timescale 1ns/1ps

module narrow_router (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  mem_island_pkg::addr_t        addr_i,
  input  logic                         we_i,
  input  mem_island_pkg::narrow_data_t wdata_i,
  input  mem_island_pkg::narrow_strb_t strb_i,
  input  logic                         gnt_i,
  input  mem_island_pkg::narrow_data_t bank_rdata_i [mem_island_pkg::NumBanks],
  output mem_island_pkg::bank_mask_t   bank_req_o,
  output mem_island_pkg::bank_addr_t   bank_addr_o,
  output logic                         we_o,
  output mem_island_pkg::narrow_data_t wdata_o,
  output mem_island_pkg::narrow_strb_t strb_o,
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output mem_island_pkg::narrow_data_t rdata_o
);

  mem_island_pkg::bank_sel_t bank_sel;
  mem_island_pkg::bank_sel_t bank_sel_q;
  logic                      accept_q;

  // Wide bank bit on top of the lane bit gives the bank number
  assign bank_sel    = addr_i[mem_island_pkg::WideBankBit:mem_island_pkg::LaneBit];
  assign bank_req_o  = req_i ? (mem_island_pkg::bank_mask_t'(1) << bank_sel) : '0;
  assign bank_addr_o = addr_i[mem_island_pkg::WordLsb +: $bits(mem_island_pkg::bank_addr_t)];
  assign we_o        = we_i;
  assign wdata_o     = wdata_i;
  assign strb_o      = strb_i;
  assign gnt_o       = gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_q <= 1'b0;
    end else begin
      accept_q <= gnt_i;
    end
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (gnt_i) begin
      bank_sel_q <= bank_sel;
    end
  end

  assign rvalid_o = accept_q;
  assign rdata_o  = bank_rdata_i[bank_sel_q];

endmodule

// File: design/sram_bank.sv
// Single-port 32-bit bank with byte enables and a one-cycle registered read.
// Contents power up undefined; the read register holds its value across writes.
`timescale 1ns/1ps

module sram_bank (
  input logic          clk_i,
  input logic          rst_ni,
  bank_port_if.bank    port_i
);

  localparam int unsigned NumBytes = mem_island_pkg::NarrowWidth / 8;

  mem_island_pkg::narrow_data_t mem_q [mem_island_pkg::WordsPerBank];
  mem_island_pkg::narrow_data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (port_i.req && port_i.we) begin
      for (int i = 0; i < NumBytes; i++) begin
        if (port_i.strb[i]) begin
          mem_q[port_i.addr][i*8 +: 8] <= port_i.wdata[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (port_i.req && !port_i.we) begin
      rdata_q <= mem_q[port_i.addr];
    end
  end

  assign port_i.rdata = rdata_q;

endmodule

// File: design/wide_splitter.sv
// Splits a 64-bit access over the two lanes of one wide bank, lane 0 in the low half.
// Both lanes are granted together, so the joined read data has a fixed latency.
`timescale 1ns/1ps

module wide_splitter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  mem_island_pkg::addr_t        addr_i,
  input  logic                         we_i,
  input  mem_island_pkg::wide_data_t   wdata_i,
  input  mem_island_pkg::wide_strb_t   strb_i,
  input  logic                         gnt_i,
  input  mem_island_pkg::narrow_data_t bank_rdata_i [mem_island_pkg::NumBanks],
  output mem_island_pkg::bank_mask_t   bank_req_o,
  output mem_island_pkg::bank_addr_t   bank_addr_o,
  output logic                         we_o,
  output mem_island_pkg::narrow_data_t lane_wdata_o [mem_island_pkg::NumLanes],
  output mem_island_pkg::narrow_strb_t lane_strb_o  [mem_island_pkg::NumLanes],
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output mem_island_pkg::wide_data_t   rdata_o
);

  localparam int unsigned LaneW = mem_island_pkg::NarrowWidth;
  localparam int unsigned StrbW = mem_island_pkg::NarrowWidth / 8;

  logic wide_sel;
  logic wide_sel_q;
  logic accept_q;

  assign wide_sel    = addr_i[mem_island_pkg::WideBankBit];
  assign bank_addr_o = addr_i[mem_island_pkg::WordLsb +: $bits(mem_island_pkg::bank_addr_t)];
  assign we_o        = we_i;
  assign gnt_o       = gnt_i;

  // Request every lane of the selected wide bank
  always_comb begin
    bank_req_o = '0;
    for (int l = 0; l < mem_island_pkg::NumLanes; l++) begin
      bank_req_o[wide_sel*mem_island_pkg::NumLanes+l] = req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_q <= 1'b0;
    end else begin
      accept_q <= gnt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_i) begin
      wide_sel_q <= wide_sel;
    end
  end

  for (genvar l = 0; l < mem_island_pkg::NumLanes; l++) begin : gen_lane
    assign lane_wdata_o[l]            = wdata_i[l*LaneW +: LaneW];
    assign lane_strb_o[l]             = strb_i[l*StrbW +: StrbW];
    assign rdata_o[l*LaneW +: LaneW]  = bank_rdata_i[wide_sel_q*mem_island_pkg::NumLanes+l];
  end

  assign rvalid_o = accept_q;

endmodule

// File: mem_island_top.f
design/mem_island_pkg.sv
design/bank_port_if.sv
design/narrow_router.sv
design/wide_splitter.sv
design/bank_arbiter.sv
design/sram_bank.sv
design/mem_island_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_island.sv

// File: verification/mem_island_input.txt
# test port(N=32-bit, W=64-bit) we addr wdata strb expected_rdata, all fields but test in hex
# writes carry 0 as expected data, reads carry 0 as write data and strobes
1 N 1 010 deadbeef f 0
1 N 0 010 0 0 deadbeef
1 N 1 3fc 76543210 f 0
1 N 0 3fc 0 0 76543210
2 N 1 024 11223344 f 0
2 N 1 024 aabbccdd 5 0
2 N 0 024 0 0 11bb33dd
2 N 1 024 55667788 a 0
2 N 0 024 0 0 55bb77dd
2 N 1 024 00000099 1 0
2 N 0 024 0 0 55bb7799
3 W 1 040 0123456789abcdef ff 0
3 N 0 040 0 0 89abcdef
3 N 0 044 0 0 01234567
3 N 1 058 cafef00d f 0
3 N 1 05c 12345678 f 0
3 W 0 058 0 0 12345678cafef00d
3 W 1 040 ffffffff00000000 30 0
3 W 0 040 0 0 0123ffff89abcdef
3 N 0 044 0 0 0123ffff

// File: verification/tb_clock_gen.sv
// Clock and reset for the testbench: 4 ns period, reset low for 8 cycles.
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

  always #2 clk_o = ~clk_o;

endmodule

// File: verification/tb_mem_island.sv
// Testbench for the banked scratchpad; run from the project root so the stimulus file is found.
// Inputs change 1 ns after the rising edge, grants and responses are sampled at the falling edge.
`timescale 1ns/1ps

module tb_mem_island;

  localparam int unsigned NumRandom   = 200;
  localparam int unsigned NumFill     = 32;
  localparam int unsigned NumDirected = 12;
  localparam string       InputFile   = "verification/mem_island_input.txt";

  logic clk;
  logic rst_n;
  logic n_req, n_gnt, n_we, n_rvalid;
  logic w_req, w_gnt, w_we, w_rvalid;
  mem_island_pkg::addr_t        n_addr, w_addr;
  mem_island_pkg::narrow_data_t n_wdata, n_rdata, n_exp;
  mem_island_pkg::narrow_strb_t n_strb;
  mem_island_pkg::wide_data_t   w_wdata, w_rdata, w_exp;
  mem_island_pkg::wide_strb_t   w_strb;

  // Byte-wide reference memory, indexed by the byte address
  logic [7:0] model_mem [2**mem_island_pkg::AddrWidth];
  logic n_due, n_read, w_due, w_read;
  int   errors, tests_run, tests_failed, err_base;

  int                         q_test [$];
  logic                       q_wide [$];
  logic                       q_we [$];
  mem_island_pkg::addr_t      q_addr [$];
  mem_island_pkg::wide_data_t q_wdata [$];
  mem_island_pkg::wide_strb_t q_strb [$];
  mem_island_pkg::wide_data_t q_exp [$];

  tb_clock_gen i_clock_gen (.clk_o(clk), .rst_no(rst_n));

  mem_island_top dut (
    .clk_i(clk), .rst_ni(rst_n),
    .narrow_req_i(n_req), .narrow_gnt_o(n_gnt), .narrow_addr_i(n_addr), .narrow_we_i(n_we),
    .narrow_wdata_i(n_wdata), .narrow_strb_i(n_strb), .narrow_rvalid_o(n_rvalid),
    .narrow_rdata_o(n_rdata),
    .wide_req_i(w_req), .wide_gnt_o(w_gnt), .wide_addr_i(w_addr), .wide_we_i(w_we),
    .wide_wdata_i(w_wdata), .wide_strb_i(w_strb), .wide_rvalid_o(w_rvalid), .wide_rdata_o(w_rdata)
  );

  function automatic mem_island_pkg::wide_data_t model_read(input mem_island_pkg::addr_t a,
                                                            input int nbytes);
    mem_island_pkg::wide_data_t d;
    int base;
    d = '0;
    base = int'(a) & ~(nbytes - 1);
    for (int i = 0; i < nbytes; i++) d[i*8 +: 8] = model_mem[base + i];
    return d;
  endfunction

  function automatic void model_write(input mem_island_pkg::addr_t a, input int nbytes,
                                      input mem_island_pkg::wide_data_t d,
                                      input mem_island_pkg::wide_strb_t s);
    int base;
    base = int'(a) & ~(nbytes - 1);
    for (int i = 0; i < nbytes; i++) begin
      if (s[i]) model_mem[base + i] = d[i*8 +: 8];
    end
  endfunction

  // Fill word built from the full address in every 16-bit slice
  function automatic mem_island_pkg::wide_data_t fill_word(input mem_island_pkg::addr_t a);
    return {4'h1, a, 4'h7, a, 4'hc, a, 4'h3, a};
  endfunction

  task automatic finish_test(input int num);
    tests_run++;
    if (errors > err_base) tests_failed++;
    $display("test %0d finished: %s (%0d errors)", num,
             (errors > err_base) ? "FAIL" : "ok", errors - err_base);
    err_base = errors;
  endtask

  task automatic check_file_value(input mem_island_pkg::wide_data_t model_v,
                                  input mem_island_pkg::wide_data_t file_v,
                                  input mem_island_pkg::addr_t a);
    assert (model_v === file_v) else begin
      $display("mismatch at %0t: reference %h differs from file value %h at %h",
               $time, model_v, file_v, a);
      errors++;
    end
  endtask

  // Starts at a rising edge and returns at the edge where the access was accepted
  task automatic narrow_access(input logic we, input mem_island_pkg::addr_t addr,
                               input mem_island_pkg::narrow_data_t wdata,
                               input mem_island_pkg::narrow_strb_t strb,
                               input mem_island_pkg::narrow_data_t file_exp,
                               input logic use_file, output int waits);
    logic g;
    mem_island_pkg::wide_data_t cur;
    g = 1'b0;
    waits = 0;
    #1;
    n_req = 1'b1;
    n_we = we;
    n_addr = addr;
    n_wdata = wdata;
    n_strb = strb;
    while (!g) begin
      @(negedge clk);
      g = n_gnt;
      @(posedge clk);
      if (!g) waits++;
    end
    if (we) begin
      model_write(addr, 4, {32'h0, wdata}, {4'h0, strb});
    end else begin
      cur = model_read(addr, 4);
      if (use_file) check_file_value(cur, {32'h0, file_exp}, addr);
      n_exp = cur[31:0];
    end
    n_read = !we;
    n_due = 1'b1;
  endtask

  task automatic wide_access(input logic we, input mem_island_pkg::addr_t addr,
                             input mem_island_pkg::wide_data_t wdata,
                             input mem_island_pkg::wide_strb_t strb,
                             input mem_island_pkg::wide_data_t file_exp,
                             input logic use_file, output int waits);
    logic g;
    g = 1'b0;
    waits = 0;
    #1;
    w_req = 1'b1;
    w_we = we;
    w_addr = addr;
    w_wdata = wdata;
    w_strb = strb;
    while (!g) begin
      @(negedge clk);
      g = w_gnt;
      @(posedge clk);
      if (!g) waits++;
    end
    if (we) begin
      model_write(addr, 8, wdata, strb);
    end else begin
      w_exp = model_read(addr, 8);
      if (use_file) check_file_value(w_exp, file_exp, addr);
    end
    w_read = !we;
    w_due = 1'b1;
  endtask

  task automatic narrow_release();
    #1 n_req = 1'b0;
    @(posedge clk);
  endtask

  task automatic wide_release();
    #1 w_req = 1'b0;
    @(posedge clk);
  endtask

  // Response monitor: exactly one rvalid, in the cycle after each acceptance
  always @(negedge clk) begin
    if (rst_n) begin
      if (n_due) begin
        assert (n_rvalid === 1'b1) else begin
          $display("narrow port gave no rvalid in the cycle after acceptance at %0t", $time);
          errors++;
        end
        if (n_read) assert (n_rdata === n_exp) else begin
          $display("mismatch at %0t: narrow read %h, expected %h", $time, n_rdata, n_exp);
          errors++;
        end
      end else begin
        assert (n_rvalid === 1'b0) else begin
          $display("narrow port raised rvalid without an accepted access at %0t", $time);
          errors++;
        end
      end
      if (w_due) begin
        assert (w_rvalid === 1'b1) else begin
          $display("wide port gave no rvalid in the cycle after acceptance at %0t", $time);
          errors++;
        end
        if (w_read) assert (w_rdata === w_exp) else begin
          $display("mismatch at %0t: wide read %h, expected %h", $time, w_rdata, w_exp);
          errors++;
        end
      end else begin
        assert (w_rvalid === 1'b0) else begin
          $display("wide port raised rvalid without an accepted access at %0t", $time);
          errors++;
        end
      end
      n_due = 1'b0;
      w_due = 1'b0;
    end
  end

  initial begin
    int fd, tnum, we_v, cur, wait_n, wait_w, first_n, budget;
    string line;
    logic [7:0] port_c;
    logic [31:0] addr_v;
    mem_island_pkg::wide_data_t wdata_v, exp_v, d;
    mem_island_pkg::wide_strb_t strb_v;
    mem_island_pkg::addr_t a;
    {n_req, n_we, n_addr, n_wdata, n_strb} = '0;
    {w_req, w_we, w_addr, w_wdata, w_strb} = '0;
    {n_due, n_read, w_due, w_read} = '0;
    n_exp = '0;
    w_exp = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    err_base = 0;
    void'($urandom(48400));

    fd = $fopen(InputFile, "r");
    assert (fd != 0) else begin
      $display("could not open the stimulus file %s", InputFile);
      errors++;
    end
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
        if ($sscanf(line, "%d %s %d %h %h %h %h", tnum, port_c, we_v, addr_v, wdata_v,
                    strb_v, exp_v) == 7) begin
          q_test.push_back(tnum);
          q_wide.push_back(port_c == 8'h57);
          q_we.push_back(we_v != 0);
          q_addr.push_back(addr_v[11:0]);
          q_wdata.push_back(wdata_v);
          q_strb.push_back(strb_v);
          q_exp.push_back(exp_v);
        end
      end
    end
    if (fd != 0) $fclose(fd);

    budget = (q_test.size() + NumRandom + NumFill + NumDirected) *
             (mem_island_pkg::WidePriorityWait + 4) * 4 + 200;
    fork
      begin
        #(budget);
        $display("watchdog expired after %0d ns, the run did not complete", budget);
        $display("Test failures found");
        $finish;
      end
    join_none

    @(posedge rst_n);
    @(posedge clk);

    // Tests 1 to 3 come from the stimulus file
    cur = (q_test.size() > 0) ? q_test[0] : 0;
    foreach (q_test[i]) begin
      if (q_test[i] != cur) begin
        finish_test(cur);
        cur = q_test[i];
      end
      if (q_wide[i]) begin
        wide_access(q_we[i], q_addr[i], q_wdata[i], q_strb[i], q_exp[i], 1'b1, wait_w);
        wide_release();
      end else begin
        narrow_access(q_we[i], q_addr[i], q_wdata[i][31:0], q_strb[i][3:0], q_exp[i][31:0],
                      1'b1, wait_n);
        narrow_release();
      end
    end
    if (q_test.size() > 0) finish_test(cur);

    // Test 4: narrow stream and a wide access on wide bank 0
    first_n = 0;
    wait_w = 0;
    fork
      begin
        narrow_access(1'b1, 12'h080, 32'h0a0b0c0d, 4'hf, '0, 1'b0, first_n);
        narrow_access(1'b1, 12'h084, 32'h1a1b1c1d, 4'hf, '0, 1'b0, wait_n);
        narrow_access(1'b1, 12'h090, 32'h2a2b2c2d, 4'hf, '0, 1'b0, wait_n);
        narrow_access(1'b1, 12'h094, 32'h3a3b3c3d, 4'hf, '0, 1'b0, wait_n);
        narrow_release();
      end
      begin
        wide_access(1'b1, 12'h0a0, 64'h5555666677778888, 8'hff, '0, 1'b0, wait_w);
        wide_release();
      end
    join
    assert (first_n == 0 && wait_w >= 1) else begin
      $display("narrow port was not granted first under contention at %0t", $time);
      errors++;
    end
    assert (wait_w <= int'(mem_island_pkg::WidePriorityWait) + 1) else begin
      $display("wide port waited %0d cycles, longer than allowed, at %0t", wait_w, $time);
      errors++;
    end
    wide_access(1'b0, 12'h0a0, '0, '0, '0, 1'b0, wait_w);
    wide_release();
    narrow_access(1'b0, 12'h094, '0, '0, '0, 1'b0, wait_n);
    narrow_release();
    finish_test(4);

    // Test 5: different wide banks are served in the same cycle
    fork
      begin
        narrow_access(1'b0, 12'h084, '0, '0, '0, 1'b0, wait_n);
        narrow_access(1'b1, 12'h0c4, 32'h600df00d, 4'hf, '0, 1'b0, first_n);
        narrow_release();
      end
      begin
        wide_access(1'b0, 12'h058, '0, '0, '0, 1'b0, wait_w);
        wide_access(1'b1, 12'h0d8, 64'h1357924680aceb0d, 8'hff, '0, 1'b0, cur);
        wide_release();
      end
    join
    assert (wait_n + wait_w + first_n + cur == 0) else begin
      $display("requests to different wide banks were not granted together at %0t", $time);
      errors++;
    end
    narrow_access(1'b0, 12'h0c4, '0, '0, '0, 1'b0, wait_n);
    narrow_release();
    wide_access(1'b0, 12'h0d8, '0, '0, '0, 1'b0, wait_w);
    wide_release();
    finish_test(5);

    // Test 6: fill the low 256 bytes, then random mixed traffic there
    for (int k = 0; k < int'(NumFill); k++) begin
      a = mem_island_pkg::addr_t'(k * 8);
      wide_access(1'b1, a, fill_word(a), 8'hff, '0, 1'b0, wait_w);
    end
    wide_release();
    for (int k = 0; k < int'(NumRandom); k++) begin
      a = mem_island_pkg::addr_t'($urandom_range(255, 0));
      d = {$urandom, $urandom};
      strb_v = mem_island_pkg::wide_strb_t'($urandom);
      if ($urandom_range(1, 0) == 1) begin
        wide_access(($urandom_range(1, 0) == 1), a, d, strb_v, '0, 1'b0, wait_w);
        wide_release();
      end else begin
        narrow_access(($urandom_range(1, 0) == 1), a, d[31:0], strb_v[3:0], '0, 1'b0, wait_n);
        narrow_release();
      end
    end
    @(posedge clk);
    @(negedge clk);
    finish_test(6);

    $display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
